// File: logic/cpu_pkg.sv
package cpu_pkg;

	// core widths and memory depths.
	localparam int xlen      = 16;
	localparam int reg_count = 16;
	localparam int reg_aw    = $clog2(reg_count);
	localparam int mem_words = 256;
	localparam int mem_aw    = $clog2(mem_words);
	localparam int apb_aw    = 12;

	// bus address map, memories are word addressed by the low bits.
	localparam logic [apb_aw-1:0] imem_base   = 12'h000;
	localparam logic [apb_aw-1:0] ctrl_addr   = 12'h100;
	localparam logic [apb_aw-1:0] status_addr = 12'h104;
	localparam logic [apb_aw-1:0] dmem_base   = 12'h200;

	// low three bits of the alu codes select the alu function.
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_or  = 4'd3,
		op_xor = 4'd4,
		op_sll = 4'd5,
		op_srl = 4'd6,
		op_sra = 4'd7,
		op_lw  = 4'd8,
		op_sw  = 4'd9,
		op_lli = 4'd10,
		op_jmp = 4'd11,
		op_hlt = 4'd12,
		op_nop = 4'd13
	} opcode_e;

	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_run    = 2'd1,
		st_halted = 2'd2
	} run_state_e;

	typedef struct packed {
		logic              valid;
		opcode_e           opcode;
		logic [xlen-1:0]   p0;
		logic [xlen-1:0]   p1;
		logic [7:0]        imm8;
		logic [3:0]        shamt;
		logic [reg_aw-1:0] dst_addr;
		logic              we_rf;
		logic              we_mem;
		logic              re_mem;
		logic [mem_aw-1:0] pc;
		logic              hlt;
	} id_ex_t;

	typedef struct packed {
		logic              we;
		logic [reg_aw-1:0] addr;
		logic [xlen-1:0]   data;
	} wb_t;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [apb_aw-1:0] paddr;
		logic [xlen-1:0]   pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [xlen-1:0] prdata;
		logic            pready;
		logic            pslverr;
	} apb_rsp_t;

endpackage

// File: logic/run_control.sv
module run_control (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cpu_pkg::apb_req_t          apb_req,
	output cpu_pkg::apb_rsp_t          apb_rsp,
	input  logic                       halted_pulse,
	input  logic [cpu_pkg::mem_aw-1:0] halt_pc,
	output logic                       run,
	output logic                       start_pulse,
	output logic                       imem_we,
	output logic [cpu_pkg::mem_aw-1:0] imem_waddr,
	output logic [cpu_pkg::xlen-1:0]   imem_wdata,
	output logic [cpu_pkg::mem_aw-1:0] dmem_req_addr,
	output logic [cpu_pkg::xlen-1:0]   dmem_req_wdata,
	output logic                       dmem_req_we,
	output logic                       dmem_req_re,
	input  logic [cpu_pkg::xlen-1:0]   dmem_rdata
);
	import cpu_pkg::*;

	run_state_e        state;
	logic [mem_aw-1:0] halt_pc_q;
	logic              rd_wait;
	logic              access;
	logic              imem_hit;
	logic              dmem_hit;
	logic              ctrl_hit;
	logic              status_hit;
	logic              dmem_rd;

	assign access     = apb_req.psel & apb_req.penable;
	assign imem_hit   = apb_req.paddr[apb_aw-1:mem_aw] == imem_base[apb_aw-1:mem_aw];
	assign dmem_hit   = apb_req.paddr[apb_aw-1:mem_aw] == dmem_base[apb_aw-1:mem_aw];
	assign ctrl_hit   = apb_req.paddr == ctrl_addr;
	assign status_hit = apb_req.paddr == status_addr;
	assign run        = (state == st_run);
	assign dmem_rd    = access & dmem_hit & ~apb_req.pwrite;

	// memory writes are refused while the core is running.
	assign imem_we        = access & imem_hit & apb_req.pwrite & ~run;
	assign imem_waddr     = apb_req.paddr[mem_aw-1:0];
	assign imem_wdata     = apb_req.pwdata;
	assign dmem_req_addr  = apb_req.paddr[mem_aw-1:0];
	assign dmem_req_wdata = apb_req.pwdata;
	assign dmem_req_we    = access & dmem_hit & apb_req.pwrite & ~run;
	assign dmem_req_re    = dmem_rd & ~rd_wait & ~run;
	assign start_pulse    = access & ctrl_hit & apb_req.pwrite & apb_req.pwdata[0] & ~run;

	always_comb begin
		apb_rsp = '0;
		// dmem reads wait one cycle for the synchronous array.
		apb_rsp.pready = ~(dmem_rd & ~rd_wait);
		if (access && apb_rsp.pready) begin
			if (!(imem_hit || dmem_hit || ctrl_hit || status_hit)) begin
				apb_rsp.pslverr = 1'b1;
			end else if ((imem_hit || dmem_hit) && run) begin
				apb_rsp.pslverr = 1'b1;
			end else if (status_hit && !apb_req.pwrite) begin
				apb_rsp.prdata = {halt_pc_q, {(xlen - mem_aw - 2){1'b0}}, state};
			end else if (dmem_rd) begin
				apb_rsp.prdata = dmem_rdata;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_wait <= 1'b0;
		end else begin
			rd_wait <= dmem_rd & ~rd_wait;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			halt_pc_q <= '0;
		end else begin
			case (state)
				st_run: begin
					if (halted_pulse) begin
						state     <= st_halted;
						halt_pc_q <= halt_pc;
					end
				end
				default: begin
					if (start_pulse) begin
						state <= st_run;
					end
				end
			endcase
		end
	end

endmodule

// File: logic/pc_counter.sv
module pc_counter (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       run,
	input  logic                       start_pulse,
	input  logic                       stall,
	input  logic                       jump_taken,
	input  logic [cpu_pkg::mem_aw-1:0] jump_target,
	output logic [cpu_pkg::mem_aw-1:0] pc
);

	// start wins over a jump, a jump wins over the increment.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (start_pulse) begin
			pc <= '0;
		end else if (jump_taken) begin
			pc <= jump_target;
		end else if (run && !stall) begin
			pc <= pc + 1'b1;
		end
	end

endmodule

// File: logic/instr_mem.sv
module instr_mem (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [cpu_pkg::mem_aw-1:0] pc,
	input  logic                       fetch_en,
	input  logic                       flush,
	input  logic                       we,
	input  logic [cpu_pkg::mem_aw-1:0] waddr,
	input  logic [cpu_pkg::xlen-1:0]   wdata,
	output logic [cpu_pkg::xlen-1:0]   instr,
	output logic [cpu_pkg::mem_aw-1:0] instr_pc,
	output logic                       instr_valid
);
	import cpu_pkg::*;

	logic [xlen-1:0] mem [mem_words];

	// program load from the bus.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// fetch register, this is the if/id boundary.
	always_ff @(posedge clk) begin
		if (fetch_en) begin
			instr    <= mem[pc];
			instr_pc <= pc;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_valid <= 1'b0;
		end else if (flush) begin
			instr_valid <= 1'b0;
		end else if (fetch_en) begin
			instr_valid <= 1'b1;
		end
	end

endmodule

// File: logic/decode_stage.sv
module decode_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [cpu_pkg::xlen-1:0]   instr,
	input  logic [cpu_pkg::mem_aw-1:0] instr_pc,
	input  logic                       instr_valid,
	input  logic                       flush,
	input  cpu_pkg::wb_t               wb,
	output cpu_pkg::id_ex_t            id_ex_next
);
	import cpu_pkg::*;

	logic [xlen-1:0]   rf [reg_count];
	opcode_e           opcode;
	logic [reg_aw-1:0] dst;
	logic [reg_aw-1:0] src1;
	logic [reg_aw-1:0] src2;
	logic [reg_aw-1:0] rd2_addr;
	logic [xlen-1:0]   p0;
	logic [xlen-1:0]   p1;

	assign dst  = instr[11:8];
	assign src1 = instr[7:4];
	assign src2 = instr[3:0];

	// codes past nop decode as nop.
	always_comb begin
		if (instr[15:12] > op_nop) begin
			opcode = op_nop;
		end else begin
			opcode = opcode_e'(instr[15:12]);
		end
	end

	// sw stores the register named in its dst field.
	assign rd2_addr = (opcode == op_sw) ? dst : src2;

	// write-through so the instruction in decode sees this cycle's writeback.
	assign p0 = (wb.we && wb.addr == src1) ? wb.data : rf[src1];
	assign p1 = (wb.we && wb.addr == rd2_addr) ? wb.data : rf[rd2_addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				rf[i] <= '0;
			end
		end else if (wb.we) begin
			rf[wb.addr] <= wb.data;
		end
	end

	always_comb begin
		id_ex_next = '0;
		// a jump or halt in execute turns this slot into a bubble.
		if (instr_valid && !flush) begin
			id_ex_next.valid    = 1'b1;
			id_ex_next.opcode   = opcode;
			id_ex_next.p0       = p0;
			id_ex_next.p1       = p1;
			id_ex_next.imm8     = instr[7:0];
			id_ex_next.shamt    = instr[3:0];
			id_ex_next.dst_addr = dst;
			id_ex_next.pc       = instr_pc;
			case (opcode)
				op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_sra,
				op_lli: begin
					id_ex_next.we_rf = 1'b1;
				end
				op_lw: begin
					id_ex_next.we_rf  = 1'b1;
					id_ex_next.re_mem = 1'b1;
				end
				op_sw: begin
					id_ex_next.we_mem = 1'b1;
				end
				op_hlt: begin
					id_ex_next.hlt = 1'b1;
				end
				// jmp is resolved in execute from the opcode.
				default: begin
					id_ex_next.we_rf = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: logic/id_ex_reg.sv
module id_ex_reg (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  logic            flush,
	input  cpu_pkg::id_ex_t d,
	output cpu_pkg::id_ex_t q
);

	// stall holds the load in execute, flush only acts when not stalled.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (!stall) begin
			if (flush) begin
				q <= '0;
			end else begin
				q <= d;
			end
		end
	end

endmodule

// File: logic/execute_stage.sv
module execute_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cpu_pkg::id_ex_t            ex,
	input  logic                       run,
	input  logic [cpu_pkg::mem_aw-1:0] dmem_req_addr,
	input  logic [cpu_pkg::xlen-1:0]   dmem_req_wdata,
	input  logic                       dmem_req_we,
	input  logic                       dmem_req_re,
	output logic [cpu_pkg::xlen-1:0]   dmem_rdata,
	output cpu_pkg::wb_t               wb,
	output logic                       stall,
	output logic                       jump_taken,
	output logic [cpu_pkg::mem_aw-1:0] jump_target,
	output logic                       halted_pulse,
	output logic [cpu_pkg::mem_aw-1:0] halt_pc
);
	import cpu_pkg::*;

	logic [xlen-1:0]   dmem [mem_words];
	logic [xlen-1:0]   rdata_q;
	logic [xlen-1:0]   alu_y;
	logic [xlen-1:0]   imm_ext;
	logic [xlen-1:0]   eff_addr;
	logic [mem_aw-1:0] mem_addr;
	logic [xlen-1:0]   mem_wdata;
	logic              mem_we;
	logic              mem_re;
	logic              load_wait;

	// base register plus zero-extended low nibble.
	assign eff_addr = ex.p0 + {{(xlen - 4){1'b0}}, ex.shamt};

	// first load cycle reads the array, the second writes back.
	assign stall = ex.valid & ex.re_mem & ~load_wait;

	// the bus only reaches the array while the core is stopped.
	assign mem_addr  = run ? eff_addr[mem_aw-1:0] : dmem_req_addr;
	assign mem_wdata = run ? ex.p1 : dmem_req_wdata;
	assign mem_we    = run ? (ex.valid & ex.we_mem) : dmem_req_we;
	assign mem_re    = run ? stall : dmem_req_re;

	always_ff @(posedge clk) begin
		if (mem_we) begin
			dmem[mem_addr] <= mem_wdata;
		end
		if (mem_re) begin
			rdata_q <= dmem[mem_addr];
		end
	end

	assign dmem_rdata = rdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_wait <= 1'b0;
		end else begin
			load_wait <= stall;
		end
	end

	always_comb begin
		case (ex.opcode)
			op_add:  alu_y = ex.p0 + ex.p1;
			op_sub:  alu_y = ex.p0 - ex.p1;
			op_and:  alu_y = ex.p0 & ex.p1;
			op_or:   alu_y = ex.p0 | ex.p1;
			op_xor:  alu_y = ex.p0 ^ ex.p1;
			op_sll:  alu_y = ex.p0 << ex.shamt;
			op_srl:  alu_y = ex.p0 >> ex.shamt;
			op_sra:  alu_y = $signed(ex.p0) >>> ex.shamt;
			default: alu_y = '0;
		endcase
	end

	assign imm_ext = {{(xlen - 8){ex.imm8[7]}}, ex.imm8};

	always_comb begin
		wb.we   = ex.valid & ex.we_rf & ~stall;
		wb.addr = ex.dst_addr;
		if (ex.re_mem) begin
			wb.data = rdata_q;
		end else if (ex.opcode == op_lli) begin
			wb.data = imm_ext;
		end else begin
			wb.data = alu_y;
		end
	end

	assign jump_taken   = ex.valid & (ex.opcode == op_jmp);
	assign jump_target  = ex.imm8[mem_aw-1:0];
	assign halted_pulse = ex.valid & ex.hlt;
	assign halt_pc      = ex.pc;

endmodule

// File: logic/cpu_top.sv
module cpu_top (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::apb_req_t apb_req,
	output cpu_pkg::apb_rsp_t apb_rsp
);
	import cpu_pkg::*;

	logic              run;
	logic              start_pulse;
	logic              imem_we;
	logic [mem_aw-1:0] imem_waddr;
	logic [xlen-1:0]   imem_wdata;
	logic [mem_aw-1:0] dmem_req_addr;
	logic [xlen-1:0]   dmem_req_wdata;
	logic              dmem_req_we;
	logic              dmem_req_re;
	logic [xlen-1:0]   dmem_rdata;
	logic [mem_aw-1:0] pc;
	logic [xlen-1:0]   instr;
	logic [mem_aw-1:0] instr_pc;
	logic              instr_valid;
	logic              stall;
	logic              flush;
	logic              fetch_en;
	logic              jump_taken;
	logic [mem_aw-1:0] jump_target;
	logic              halted_pulse;
	logic [mem_aw-1:0] halt_pc;
	wb_t               wb;
	id_ex_t            id_ex_next;
	id_ex_t            id_ex_q;

	// younger instructions are dropped on a jump, a halt or while stopped.
	assign flush    = jump_taken | halted_pulse | ~run;
	assign fetch_en = run & ~stall;

	run_control u_run_control (
		.clk            (clk),
		.rst_n          (rst_n),
		.apb_req        (apb_req),
		.apb_rsp        (apb_rsp),
		.halted_pulse   (halted_pulse),
		.halt_pc        (halt_pc),
		.run            (run),
		.start_pulse    (start_pulse),
		.imem_we        (imem_we),
		.imem_waddr     (imem_waddr),
		.imem_wdata     (imem_wdata),
		.dmem_req_addr  (dmem_req_addr),
		.dmem_req_wdata (dmem_req_wdata),
		.dmem_req_we    (dmem_req_we),
		.dmem_req_re    (dmem_req_re),
		.dmem_rdata     (dmem_rdata)
	);

	pc_counter u_pc_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.start_pulse (start_pulse),
		.stall       (stall),
		.jump_taken  (jump_taken),
		.jump_target (jump_target),
		.pc          (pc)
	);

	instr_mem u_instr_mem (
		.clk         (clk),
		.rst_n       (rst_n),
		.pc          (pc),
		.fetch_en    (fetch_en),
		.flush       (flush),
		.we          (imem_we),
		.waddr       (imem_waddr),
		.wdata       (imem_wdata),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.instr_valid (instr_valid)
	);

	decode_stage u_decode_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.instr_valid (instr_valid),
		.flush       (flush),
		.wb          (wb),
		.id_ex_next  (id_ex_next)
	);

	id_ex_reg u_id_ex_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.stall (stall),
		.flush (flush),
		.d     (id_ex_next),
		.q     (id_ex_q)
	);

	execute_stage u_execute_stage (
		.clk            (clk),
		.rst_n          (rst_n),
		.ex             (id_ex_q),
		.run            (run),
		.dmem_req_addr  (dmem_req_addr),
		.dmem_req_wdata (dmem_req_wdata),
		.dmem_req_we    (dmem_req_we),
		.dmem_req_re    (dmem_req_re),
		.dmem_rdata     (dmem_rdata),
		.wb             (wb),
		.stall          (stall),
		.jump_taken     (jump_taken),
		.jump_target    (jump_target),
		.halted_pulse   (halted_pulse),
		.halt_pc        (halt_pc)
	);

endmodule

// File: bench/cpu_tb.sv
module cpu_tb;
	import cpu_pkg::*;

	localparam int num_tests       = 5;
	localparam int cycles_per_test = 200;

	logic              clk;
	logic              rst_n;
	apb_req_t          apb_req;
	apb_rsp_t          apb_rsp;
	logic [xlen-1:0]   prog [$];
	logic [xlen-1:0]   m_rf [reg_count];
	logic [xlen-1:0]   m_dmem [mem_words];
	string             cur_test;
	int                errors;
	int                checks;
	int                test_errors;
	int                tests_failed;

	cpu_top uut (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [15:0] enc(opcode_e op, int d, int s1, int s2);
		return {op, d[3:0], s1[3:0], s2[3:0]};
	endfunction

	function automatic logic [15:0] enc_imm(opcode_e op, int d, int imm);
		return {op, d[3:0], imm[7:0]};
	endfunction

	task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp) else begin
			$display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic apb_transfer(input logic write, input logic [11:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata, output logic err);
		int waits;
		int exp_waits;
		waits     = 0;
		// only a dmem read waits, one cycle for the synchronous array.
		exp_waits = (!write && addr[11:8] == dmem_base[11:8]) ? 1 : 0;
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		// the response is combinational, so sample it after the request settles.
		#1;
		while (!apb_rsp.pready) begin
			waits++;
			@(negedge clk);
			#1;
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		check_value("wait states", 16'(exp_waits), 16'(waits));
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [15:0] data, output logic err);
		logic [15:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [15:0] data, output logic err);
		apb_transfer(1'b0, addr, 16'h0000, data, err);
	endtask

	// instruction set model that runs prog from pc 0 until hlt.
	task automatic model_run(output logic [7:0] hpc);
		logic [7:0]  mpc;
		logic [7:0]  nxt;
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] ea;
		mpc = 8'h00;
		hpc = 8'h00;
		for (int step = 0; step < 256; step++) begin
			ins = (mpc < prog.size()) ? prog[mpc] : enc(op_nop, 0, 0, 0);
			a   = m_rf[ins[7:4]];
			b   = m_rf[ins[3:0]];
			ea  = a + {12'h000, ins[3:0]};
			nxt = mpc + 8'h01;
			case (ins[15:12])
				op_add: m_rf[ins[11:8]] = a + b;
				op_sub: m_rf[ins[11:8]] = a - b;
				op_and: m_rf[ins[11:8]] = a & b;
				op_or:  m_rf[ins[11:8]] = a | b;
				op_xor: m_rf[ins[11:8]] = a ^ b;
				op_sll: m_rf[ins[11:8]] = a << ins[3:0];
				op_srl: m_rf[ins[11:8]] = a >> ins[3:0];
				op_sra: m_rf[ins[11:8]] = $signed(a) >>> ins[3:0];
				op_lw:  m_rf[ins[11:8]] = m_dmem[ea[7:0]];
				op_sw:  m_dmem[ea[7:0]] = m_rf[ins[11:8]];
				op_lli: m_rf[ins[11:8]] = {{8{ins[7]}}, ins[7:0]};
				op_jmp: nxt = ins[7:0];
				op_hlt: begin
					hpc = mpc;
					break;
				end
				default: ;
			endcase
			mpc = nxt;
		end
	endtask

	task automatic dmem_poke(input logic [7:0] addr, input logic [15:0] data);
		logic err;
		apb_write(dmem_base + addr, data, err);
		check_value("dmem write error", 16'h0000, err);
		m_dmem[addr] = data;
	endtask

	task automatic dmem_check(input logic [7:0] addr);
		logic [15:0] data;
		logic        err;
		apb_read(dmem_base + addr, data, err);
		check_value($sformatf("dmem[%h] error", addr), 16'h0000, err);
		check_value($sformatf("dmem[%h]", addr), m_dmem[addr], data);
	endtask

	task automatic load_program();
		logic err;
		foreach (prog[i]) begin
			apb_write(imem_base + i, prog[i], err);
			check_value("imem write error", 16'h0000, err);
		end
	endtask

	task automatic start_core();
		logic err;
		apb_write(ctrl_addr, 16'h0001, err);
		check_value("ctrl write error", 16'h0000, err);
	endtask

	// poll status until the core reports halted, then compare the halt pc.
	task automatic finish_run(input logic [7:0] hpc);
		logic [15:0] status;
		logic        err;
		status = '0;
		while (status[1:0] != st_halted) begin
			apb_read(status_addr, status, err);
		end
		check_value("status", {hpc, 6'b000000, st_halted}, status);
	endtask

	task automatic run_program();
		logic [7:0] hpc;
		load_program();
		model_run(hpc);
		start_core();
		finish_run(hpc);
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		if (errors == test_errors) begin
			$display("%s: passed", cur_test);
		end else begin
			$display("%s: failed with %0d errors", cur_test, errors - test_errors);
			tests_failed++;
		end
	endtask

	task automatic test_bus_access();
		logic [15:0] words [8];
		logic [15:0] rdata;
		logic [15:0] keep;
		logic [7:0]  hpc;
		logic        err;
		begin_test("bus_access");
		for (int i = 0; i < 8; i++) begin
			words[i] = $urandom;
			dmem_poke(8'h40 + i, words[i]);
		end
		for (int i = 0; i < 8; i++) begin
			dmem_check(8'h40 + i);
		end
		// a long nop run keeps the core busy while the bus pokes at it.
		prog = {};
		prog.push_back(enc_imm(op_lli, 0, 8'h00));
		prog.push_back(enc_imm(op_lli, 1, 8'h5a));
		for (int i = 0; i < 28; i++) begin
			prog.push_back(enc(op_nop, 0, 0, 0));
		end
		prog.push_back(enc(op_hlt, 0, 0, 0));
		keep = $urandom;
		dmem_poke(8'h03, keep);
		load_program();
		model_run(hpc);
		start_core();
		apb_write(dmem_base + 12'h003, ~keep, err);
		check_value("dmem write while running", 16'h0001, err);
		apb_write(imem_base + 12'h014, enc(op_sw, 1, 0, 3), err);
		check_value("imem write while running", 16'h0001, err);
		finish_run(hpc);
		dmem_check(8'h03);
		apb_read(12'h300, rdata, err);
		check_value("unmapped error", 16'h0001, err);
		check_value("unmapped data", 16'h0000, rdata);
		end_test();
	endtask

	task automatic test_alu_ops();
		begin_test("alu_ops");
		prog = {};
		prog.push_back(enc_imm(op_lli, 1, $urandom));
		prog.push_back(enc_imm(op_lli, 2, $urandom));
		prog.push_back(enc_imm(op_lli, 12, 8'h70));
		prog.push_back(enc(op_add, 3, 1, 2));
		prog.push_back(enc(op_sub, 4, 1, 2));
		prog.push_back(enc(op_and, 5, 1, 2));
		prog.push_back(enc(op_or, 6, 1, 2));
		prog.push_back(enc(op_xor, 7, 1, 2));
		prog.push_back(enc(op_sll, 8, 1, $urandom));
		prog.push_back(enc(op_srl, 9, 1, $urandom));
		prog.push_back(enc(op_sra, 10, 1, $urandom));
		// depends on the two results just before it.
		prog.push_back(enc(op_add, 11, 10, 9));
		for (int r = 3; r <= 11; r++) begin
			prog.push_back(enc(op_sw, r, 12, r - 3));
		end
		prog.push_back(enc(op_hlt, 0, 0, 0));
		run_program();
		for (int i = 0; i < 9; i++) begin
			dmem_check(8'h70 + i);
		end
		end_test();
	endtask

	task automatic test_load_stall();
		begin_test("load_stall");
		dmem_poke(8'h30, $urandom);
		prog = {};
		prog.push_back(enc_imm(op_lli, 1, 8'h30));
		prog.push_back(enc_imm(op_lli, 2, $urandom));
		prog.push_back(enc(op_lw, 3, 1, 0));
		prog.push_back(enc(op_add, 4, 3, 2));
		prog.push_back(enc(op_sw, 4, 1, 1));
		prog.push_back(enc(op_hlt, 0, 0, 0));
		run_program();
		dmem_check(8'h31);
		end_test();
	endtask

	task automatic test_jump_flush();
		begin_test("jump_flush");
		dmem_poke(8'h50, $urandom);
		dmem_poke(8'h51, 16'h0000);
		prog = {};
		prog.push_back(enc_imm(op_lli, 1, 8'h50));
		prog.push_back(enc_imm(op_lli, 2, 8'h11));
		prog.push_back(enc_imm(op_jmp, 0, 8'h05));
		prog.push_back(enc(op_sw, 2, 1, 0));
		prog.push_back(enc(op_sw, 2, 1, 0));
		prog.push_back(enc_imm(op_lli, 3, 8'h22));
		prog.push_back(enc(op_sw, 3, 1, 1));
		prog.push_back(enc(op_hlt, 0, 0, 0));
		run_program();
		dmem_check(8'h50);
		dmem_check(8'h51);
		end_test();
	endtask

	task automatic test_halt_restart();
		logic [7:0] hpc;
		begin_test("halt_restart");
		dmem_poke(8'h60, $urandom);
		dmem_poke(8'h61, $urandom);
		prog = {};
		prog.push_back(enc_imm(op_lli, 1, 8'h60));
		prog.push_back(enc_imm(op_lli, 2, 8'h33));
		prog.push_back(enc(op_sw, 2, 1, 0));
		prog.push_back(enc(op_hlt, 0, 0, 0));
		prog.push_back(enc_imm(op_lli, 2, 8'h44));
		prog.push_back(enc(op_sw, 2, 1, 1));
		run_program();
		dmem_check(8'h60);
		dmem_check(8'h61);
		// second start runs the same program again from pc 0.
		dmem_poke(8'h60, $urandom);
		model_run(hpc);
		start_core();
		finish_run(hpc);
		dmem_check(8'h60);
		dmem_check(8'h61);
		end_test();
	endtask

	initial begin
		void'($urandom(37));
		errors       = 0;
		checks       = 0;
		tests_failed = 0;
		apb_req      = '0;
		rst_n        = 1'b0;
		foreach (m_rf[i]) begin
			m_rf[i] = '0;
		end
		foreach (m_dmem[i]) begin
			m_dmem[i] = '0;
		end
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		test_bus_access();
		test_alu_ops();
		test_load_stall();
		test_jump_flush();
		test_halt_restart();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			num_tests, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		repeat (num_tests * cycles_per_test + 10) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: project.f
logic/cpu_pkg.sv
logic/run_control.sv
logic/pc_counter.sv
logic/instr_mem.sv
logic/decode_stage.sv
logic/id_ex_reg.sv
logic/execute_stage.sv
logic/cpu_top.sv
bench/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - logic/cpu_pkg.sv
  - logic/run_control.sv
  - logic/pc_counter.sv
  - logic/instr_mem.sv
  - logic/decode_stage.sv
  - logic/id_ex_reg.sv
  - logic/execute_stage.sv
  - logic/cpu_top.sv
  - target: simulation
    files:
      - bench/cpu_tb.sv
